// File: Bender.yml
package:
  name: riscv_top

sources:
  - rtl/RiscvPkg.sv
  - rtl/CoreCtrlPkg.sv
  - rtl/InstDecoder.sv
  - rtl/Alu.sv
  - rtl/LoadStoreUnit.sv
  - rtl/CoreSequencer.sv
  - rtl/RiscvTop.sv
  - target: simulation
    files:
      - verification/ClockGen.sv
      - verification/RiscvTop_chk.sv
      - verification/RiscvTopTb.sv

// File: RiscvTop.f
rtl/RiscvPkg.sv
rtl/CoreCtrlPkg.sv
rtl/InstDecoder.sv
rtl/Alu.sv
rtl/LoadStoreUnit.sv
rtl/CoreSequencer.sv
rtl/RiscvTop.sv
verification/ClockGen.sv
verification/RiscvTop_chk.sv
verification/RiscvTopTb.sv

// File: rtl/Alu.sv
module Alu (
	input  RiscvPkg::word_t  opA,
	input  RiscvPkg::word_t  opB,
	input  RiscvPkg::aluOp_e op,
	input  logic [2:0]       funct3,
	output RiscvPkg::word_t  result,
	output logic             branchTaken
);

	logic [4:0] shamt;
	logic isEq;
	logic isLt;
	logic isLtu;

	assign shamt = opB[4:0];
	assign isEq = (opA == opB);
	assign isLt = ($signed(opA) < $signed(opB));
	assign isLtu = (opA < opB);

	always_comb begin
		case (op)
			RiscvPkg::AluAdd:   result = opA + opB;
			RiscvPkg::AluSub:   result = opA - opB;
			RiscvPkg::AluSll:   result = opA << shamt;
			RiscvPkg::AluSlt:   result = {31'b0, isLt};
			RiscvPkg::AluSltu:  result = {31'b0, isLtu};
			RiscvPkg::AluXor:   result = opA ^ opB;
			RiscvPkg::AluSrl:   result = opA >> shamt;
			RiscvPkg::AluSra:   result = $signed(opA) >>> shamt;
			RiscvPkg::AluOr:    result = opA | opB;
			RiscvPkg::AluAnd:   result = opA & opB;
			default:            result = opB;
		endcase
	end

	// branch condition on rs1 vs rs2
	always_comb begin
		case (funct3)
			RiscvPkg::F3Beq:  branchTaken = isEq;
			RiscvPkg::F3Bne:  branchTaken = !isEq;
			RiscvPkg::F3Blt:  branchTaken = isLt;
			RiscvPkg::F3Bge:  branchTaken = !isLt;
			RiscvPkg::F3Bltu: branchTaken = isLtu;
			RiscvPkg::F3Bgeu: branchTaken = !isLtu;
			default:          branchTaken = 1'b0;
		endcase
	end

endmodule

// File: rtl/CoreCtrlPkg.sv
package CoreCtrlPkg;

	typedef enum logic [2:0] {
		StFetch,
		StDecode,
		StExecute,
		StMemory,
		StWriteback,
		StHalted
	} seqState_e;

	// source of the register write data
	typedef enum logic [1:0] {
		WbAlu,
		WbLoad,
		WbPc4
	} wbSel_e;

	typedef struct packed {
		RiscvPkg::aluOp_e aluOp;
		logic             srcAIsPc;
		logic             srcBIsImm;
		logic             isBranch;
		logic             isJal;
		logic             isJalr;
		logic             memRead;
		logic             memWrite;
		logic [1:0]       memSize;
		logic             loadUnsigned;
		logic             regWrite;
		wbSel_e           wbSel;
		logic [2:0]       funct3;
		RiscvPkg::word_t  imm;
	} ctrl_t;

endpackage

// File: rtl/CoreSequencer.sv
module CoreSequencer #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,
	output logic                 iMemCsn,
	output logic [AddrWidth-1:0] iMemAddr,
	input  RiscvPkg::word_t      iMemData,
	output RiscvPkg::word_t      inst,
	input  CoreCtrlPkg::ctrl_t   ctrl,
	input  logic                 isHaltInst,
	input  RiscvPkg::word_t      rs1Val,
	input  RiscvPkg::word_t      rs2Val,
	output RiscvPkg::regIdx_t    raddr1,
	output RiscvPkg::regIdx_t    raddr2,
	output RiscvPkg::regIdx_t    waddr,
	output RiscvPkg::word_t      aluA,
	output RiscvPkg::word_t      aluB,
	input  RiscvPkg::word_t      aluResult,
	input  logic                 branchTaken,
	output logic                 dMemCsn,
	output logic                 dMemWen,
	output RiscvPkg::word_t      exResult,
	input  RiscvPkg::word_t      loadData,
	output logic                 rfWe,
	output RiscvPkg::word_t      rfWd,
	output logic                 halt,
	output logic [31:0]          numInst
);

	CoreCtrlPkg::seqState_e state;
	CoreCtrlPkg::seqState_e nextState;
	RiscvPkg::addr_t pc;
	RiscvPkg::addr_t nextPc;
	RiscvPkg::word_t instReg;
	RiscvPkg::word_t rs1Reg;
	RiscvPkg::word_t rs2Reg;
	logic haltHit;

	// fetched word arrives during Decode, held afterwards
	assign inst = (state == CoreCtrlPkg::StDecode) ? iMemData : instReg;
	assign raddr1 = inst[19:15];
	assign raddr2 = inst[24:20];
	assign waddr = inst[11:7];
	assign iMemAddr = pc[AddrWidth-1:0];

	assign aluA = ctrl.srcAIsPc ? pc : rs1Reg;
	assign aluB = ctrl.srcBIsImm ? ctrl.imm : rs2Reg;

	assign haltHit = isHaltInst && (rs1Val == RiscvPkg::HaltMagic);
	assign halt = (state == CoreCtrlPkg::StHalted) || (state == CoreCtrlPkg::StDecode && haltHit);

	assign rfWe = (state == CoreCtrlPkg::StWriteback) && ctrl.regWrite;
	assign rfWd = (ctrl.wbSel == CoreCtrlPkg::WbLoad) ? loadData : exResult;

	always_comb begin
		if (ctrl.isJalr)
			nextPc = aluResult & ~32'd1;
		else if (ctrl.isJal || (ctrl.isBranch && branchTaken))
			nextPc = pc + ctrl.imm;
		else
			nextPc = pc + 32'd4;
	end

	always_comb begin
		case (state)
			// stay until the fetch request has gone out
			CoreCtrlPkg::StFetch:
				nextState = iMemCsn ? CoreCtrlPkg::StFetch : CoreCtrlPkg::StDecode;
			CoreCtrlPkg::StDecode:
				nextState = haltHit ? CoreCtrlPkg::StHalted : CoreCtrlPkg::StExecute;
			CoreCtrlPkg::StExecute:
				if (ctrl.memRead || ctrl.memWrite)
					nextState = CoreCtrlPkg::StMemory;
				else if (ctrl.regWrite)
					nextState = CoreCtrlPkg::StWriteback;
				else
					nextState = CoreCtrlPkg::StFetch;
			CoreCtrlPkg::StMemory:
				nextState = ctrl.memRead ? CoreCtrlPkg::StWriteback : CoreCtrlPkg::StFetch;
			CoreCtrlPkg::StWriteback:
				nextState = CoreCtrlPkg::StFetch;
			default:
				nextState = CoreCtrlPkg::StHalted;
		endcase
	end

	// strobes follow the state being entered
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state <= CoreCtrlPkg::StFetch;
			pc <= '0;
			numInst <= '0;
			iMemCsn <= 1'b1;
			dMemCsn <= 1'b1;
			dMemWen <= 1'b1;
		end else begin
			state <= nextState;
			iMemCsn <= (nextState != CoreCtrlPkg::StFetch);
			dMemCsn <= (nextState != CoreCtrlPkg::StMemory);
			dMemWen <= !(nextState == CoreCtrlPkg::StMemory && ctrl.memWrite);
			if (state == CoreCtrlPkg::StExecute)
				pc <= nextPc;
			// one retired instruction per return to Fetch
			if (state != CoreCtrlPkg::StFetch && nextState == CoreCtrlPkg::StFetch)
				numInst <= numInst + 32'd1;
		end
	end

	always_ff @(posedge CLK) begin
		if (state == CoreCtrlPkg::StDecode) begin
			instReg <= iMemData;
			rs1Reg <= rs1Val;
			rs2Reg <= rs2Val;
		end
		// link address replaces the ALU result for jumps
		if (state == CoreCtrlPkg::StExecute)
			exResult <= (ctrl.wbSel == CoreCtrlPkg::WbPc4) ? pc + 32'd4 : aluResult;
	end

endmodule

// File: rtl/InstDecoder.sv
module InstDecoder (
	input  RiscvPkg::word_t    inst,
	output CoreCtrlPkg::ctrl_t ctrl,
	output logic               isHaltInst
);

	RiscvPkg::word_t immI;
	RiscvPkg::word_t immS;
	RiscvPkg::word_t immB;
	RiscvPkg::word_t immU;
	RiscvPkg::word_t immJ;

	// alt selects sub/sra; only register ops may pick sub
	function automatic RiscvPkg::aluOp_e aluFromFunct(input logic [2:0] f3, input logic alt,
			input logic isReg);
		RiscvPkg::aluOp_e op;
		case (f3)
			RiscvPkg::F3AddSub: op = (isReg && alt) ? RiscvPkg::AluSub : RiscvPkg::AluAdd;
			RiscvPkg::F3Sll:    op = RiscvPkg::AluSll;
			RiscvPkg::F3Slt:    op = RiscvPkg::AluSlt;
			RiscvPkg::F3Sltu:   op = RiscvPkg::AluSltu;
			RiscvPkg::F3Xor:    op = RiscvPkg::AluXor;
			RiscvPkg::F3Srl:    op = alt ? RiscvPkg::AluSra : RiscvPkg::AluSrl;
			RiscvPkg::F3Or:     op = RiscvPkg::AluOr;
			default:            op = RiscvPkg::AluAnd;
		endcase
		return op;
	endfunction

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign isHaltInst = (inst == RiscvPkg::HaltInst);

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = RiscvPkg::AluAdd;
		ctrl.wbSel = CoreCtrlPkg::WbAlu;
		ctrl.funct3 = inst[14:12];
		ctrl.memSize = inst[13:12];
		ctrl.loadUnsigned = inst[14];
		case (inst[6:0])
			RiscvPkg::OpLui: begin
				ctrl.aluOp = RiscvPkg::AluPassB;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.imm = immU;
			end
			RiscvPkg::OpAuipc: begin
				ctrl.srcAIsPc = 1'b1;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.imm = immU;
			end
			RiscvPkg::OpJal: begin
				ctrl.isJal = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = CoreCtrlPkg::WbPc4;
				ctrl.imm = immJ;
			end
			RiscvPkg::OpJalr: begin
				ctrl.isJalr = 1'b1;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = CoreCtrlPkg::WbPc4;
				ctrl.imm = immI;
			end
			RiscvPkg::OpBranch: begin
				ctrl.isBranch = 1'b1;
				ctrl.imm = immB;
			end
			RiscvPkg::OpLoad: begin
				ctrl.memRead = 1'b1;
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = CoreCtrlPkg::WbLoad;
				ctrl.imm = immI;
			end
			RiscvPkg::OpStore: begin
				ctrl.memWrite = 1'b1;
				ctrl.srcBIsImm = 1'b1;
				ctrl.imm = immS;
			end
			RiscvPkg::OpImm: begin
				ctrl.aluOp = aluFromFunct(inst[14:12], inst[30], 1'b0);
				ctrl.srcBIsImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.imm = immI;
			end
			RiscvPkg::OpReg: begin
				ctrl.aluOp = aluFromFunct(inst[14:12], inst[30], 1'b1);
				ctrl.regWrite = 1'b1;
			end
			default: begin
				// unsupported opcodes retire as no-ops
				ctrl.imm = '0;
			end
		endcase
	end

endmodule

// File: rtl/LoadStoreUnit.sv
module LoadStoreUnit #(
	parameter int AddrWidth = 12
) (
	input  logic [AddrWidth-1:0] byteAddr,
	input  logic [1:0]           memSize,
	input  logic                 loadUnsigned,
	input  RiscvPkg::word_t      storeData,
	input  RiscvPkg::word_t      memRdata,
	output logic [3:0]           byteEn,
	output RiscvPkg::word_t      memWdata,
	output RiscvPkg::word_t      loadData,
	output logic [AddrWidth-1:0] wordAddr
);

	logic [1:0] lane;
	RiscvPkg::word_t shifted;

	assign lane = byteAddr[1:0];
	assign wordAddr = {2'b00, byteAddr[AddrWidth-1:2]};

	// misaligned halves fall back to the aligned half
	always_comb begin
		case (memSize)
			RiscvPkg::MemByte: begin
				byteEn = 4'b0001 << lane;
				memWdata = {4{storeData[7:0]}};
				shifted = memRdata >> {lane, 3'b000};
			end
			RiscvPkg::MemHalf: begin
				byteEn = lane[1] ? 4'b1100 : 4'b0011;
				memWdata = {2{storeData[15:0]}};
				shifted = lane[1] ? (memRdata >> 16) : memRdata;
			end
			default: begin
				byteEn = 4'b1111;
				memWdata = storeData;
				shifted = memRdata;
			end
		endcase
	end

	always_comb begin
		case (memSize)
			RiscvPkg::MemByte:
				loadData = {{24{shifted[7] & !loadUnsigned}}, shifted[7:0]};
			RiscvPkg::MemHalf:
				loadData = {{16{shifted[15] & !loadUnsigned}}, shifted[15:0]};
			default:
				loadData = shifted;
		endcase
	end

endmodule

// File: rtl/RiscvPkg.sv
package RiscvPkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] regIdx_t;

	// major opcodes, bits [6:0]
	typedef enum logic [6:0] {
		OpLui    = 7'b0110111,
		OpAuipc  = 7'b0010111,
		OpJal    = 7'b1101111,
		OpJalr   = 7'b1100111,
		OpBranch = 7'b1100011,
		OpLoad   = 7'b0000011,
		OpStore  = 7'b0100011,
		OpImm    = 7'b0010011,
		OpReg    = 7'b0110011
	} opcode_e;

	// funct3 of OP and OP-IMM
	localparam logic [2:0] F3AddSub = 3'b000;
	localparam logic [2:0] F3Sll    = 3'b001;
	localparam logic [2:0] F3Slt    = 3'b010;
	localparam logic [2:0] F3Sltu   = 3'b011;
	localparam logic [2:0] F3Xor    = 3'b100;
	localparam logic [2:0] F3Srl    = 3'b101;
	localparam logic [2:0] F3Or     = 3'b110;
	localparam logic [2:0] F3And    = 3'b111;

	// funct3 of branches
	localparam logic [2:0] F3Beq  = 3'b000;
	localparam logic [2:0] F3Bne  = 3'b001;
	localparam logic [2:0] F3Blt  = 3'b100;
	localparam logic [2:0] F3Bge  = 3'b101;
	localparam logic [2:0] F3Bltu = 3'b110;
	localparam logic [2:0] F3Bgeu = 3'b111;

	// access size, funct3[1:0] of loads and stores
	localparam logic [1:0] MemByte = 2'b00;
	localparam logic [1:0] MemHalf = 2'b01;
	localparam logic [1:0] MemWord = 2'b10;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor,
		AluSrl, AluSra, AluOr, AluAnd, AluPassB
	} aluOp_e;

	// jalr x0, 0(x1)
	localparam word_t HaltInst  = 32'h0000_8067;
	localparam word_t HaltMagic = 32'd12;

endpackage

// File: rtl/RiscvTop.sv
module RiscvTop #(
	parameter int AddrWidth = 12
) (
	input  logic                 CLK,
	input  logic                 RSTn,
	output logic                 I_MEM_CSN,
	input  logic [31:0]          I_MEM_DI,
	output logic [AddrWidth-1:0] I_MEM_ADDR,
	output logic                 D_MEM_CSN,
	input  logic [31:0]          D_MEM_DI,
	output logic [31:0]          D_MEM_DOUT,
	output logic [AddrWidth-1:0] D_MEM_ADDR,
	output logic                 D_MEM_WEN,
	output logic [3:0]           D_MEM_BE,
	output logic                 RF_WE,
	output logic [4:0]           RF_RA1,
	output logic [4:0]           RF_RA2,
	output logic [4:0]           RF_WA1,
	input  logic [31:0]          RF_RD1,
	input  logic [31:0]          RF_RD2,
	output logic [31:0]          RF_WD,
	output logic                 HALT,
	output logic [31:0]          NUM_INST,
	output logic [31:0]          OUTPUT_PORT
);

	RiscvPkg::word_t inst;
	CoreCtrlPkg::ctrl_t ctrl;
	logic isHaltInst;
	RiscvPkg::word_t aluA;
	RiscvPkg::word_t aluB;
	RiscvPkg::word_t aluResult;
	logic branchTaken;
	RiscvPkg::word_t exResult;
	RiscvPkg::word_t loadData;

	assign OUTPUT_PORT = RF_WD;

	CoreSequencer #(.AddrWidth(AddrWidth)) sequencer (
		.CLK(CLK), .RSTn(RSTn),
		.iMemCsn(I_MEM_CSN), .iMemAddr(I_MEM_ADDR), .iMemData(I_MEM_DI),
		.inst(inst), .ctrl(ctrl), .isHaltInst(isHaltInst),
		.rs1Val(RF_RD1), .rs2Val(RF_RD2),
		.raddr1(RF_RA1), .raddr2(RF_RA2), .waddr(RF_WA1),
		.aluA(aluA), .aluB(aluB), .aluResult(aluResult), .branchTaken(branchTaken),
		.dMemCsn(D_MEM_CSN), .dMemWen(D_MEM_WEN), .exResult(exResult), .loadData(loadData),
		.rfWe(RF_WE), .rfWd(RF_WD),
		.halt(HALT), .numInst(NUM_INST)
	);

	InstDecoder decoder (.inst(inst), .ctrl(ctrl), .isHaltInst(isHaltInst));

	Alu alu (
		.opA(aluA), .opB(aluB), .op(ctrl.aluOp), .funct3(ctrl.funct3),
		.result(aluResult), .branchTaken(branchTaken)
	);

	// store data is read from RF port 2, still addressed by rs2
	LoadStoreUnit #(.AddrWidth(AddrWidth)) lsu (
		.byteAddr(exResult[AddrWidth-1:0]), .memSize(ctrl.memSize),
		.loadUnsigned(ctrl.loadUnsigned), .storeData(RF_RD2), .memRdata(D_MEM_DI),
		.byteEn(D_MEM_BE), .memWdata(D_MEM_DOUT), .loadData(loadData),
		.wordAddr(D_MEM_ADDR)
	);

endmodule

// File: verification/ClockGen.sv
module ClockGen #(
	parameter int Period = 4
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever #(Period / 2) CLK = ~CLK;
	end

endmodule

// File: verification/RiscvTopTb.sv
module RiscvTopTb;

	localparam int AddrWidth = 12;
	localparam int NumRandom = 200;
	localparam int ProgLen = NumRandom + 3;
	localparam int CycleLimit = NumRandom * 5 + 200;

	typedef struct packed {
		logic [4:0]  idx;
		logic [31:0] value;
	} regWrite_t;

	typedef struct packed {
		logic [AddrWidth-1:0] addr;
		logic [3:0]           be;
		logic [31:0]          data;
	} memWrite_t;

	logic CLK;
	logic RSTn;
	logic iMemCsn;
	logic [31:0] iMemDi;
	logic [AddrWidth-1:0] iMemAddr;
	logic dMemCsn;
	logic [31:0] dMemDi;
	logic [31:0] dMemDout;
	logic [AddrWidth-1:0] dMemAddr;
	logic dMemWen;
	logic [3:0] dMemBe;
	logic rfWe;
	logic [4:0] rfRa1;
	logic [4:0] rfRa2;
	logic [4:0] rfWa1;
	logic [31:0] rfRd1;
	logic [31:0] rfRd2;
	logic [31:0] rfWd;
	logic halt;
	logic [31:0] numInst;
	logic [31:0] outputPort;

	logic [31:0] imem [1024];
	logic [31:0] dmem [1024];
	logic [31:0] rf [32];
	logic [31:0] modelMem [1024];
	logic [31:0] modelReg [32];

	regWrite_t expRegQ[$];
	memWrite_t expMemQ[$];
	logic [31:0] expPcQ[$];
	int expCount;
	int cycles = 0;

	ClockGen #(.Period(4)) clockGen (.CLK(CLK));

	RiscvTop #(.AddrWidth(AddrWidth)) RiscvTop_inst (
		.CLK(CLK), .RSTn(RSTn),
		.I_MEM_CSN(iMemCsn), .I_MEM_DI(iMemDi), .I_MEM_ADDR(iMemAddr),
		.D_MEM_CSN(dMemCsn), .D_MEM_DI(dMemDi), .D_MEM_DOUT(dMemDout),
		.D_MEM_ADDR(dMemAddr), .D_MEM_WEN(dMemWen), .D_MEM_BE(dMemBe),
		.RF_WE(rfWe), .RF_RA1(rfRa1), .RF_RA2(rfRa2), .RF_WA1(rfWa1),
		.RF_RD1(rfRd1), .RF_RD2(rfRd2), .RF_WD(rfWd),
		.HALT(halt), .NUM_INST(numInst), .OUTPUT_PORT(outputPort)
	);

	bind RiscvTop RiscvTopChk portChk (
		.CLK(CLK), .RSTn(RSTn), .iMemCsn(I_MEM_CSN), .dMemCsn(D_MEM_CSN),
		.dMemWen(D_MEM_WEN), .rfWe(RF_WE), .halt(HALT)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else failRun($sformatf("MISMATCH %s expected 0x%08h got 0x%08h", name, exp, got));
	endtask

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, RiscvPkg::OpReg};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], RiscvPkg::OpStore};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], RiscvPkg::OpBranch};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, RiscvPkg::OpJal};
	endfunction

	// x0 or x3..x31 since x1 and x2 stay reserved
	function automatic logic [4:0] pickRd();
		int r;
		r = $urandom % 30;
		return (r == 0) ? 5'd0 : 5'(r + 2);
	endfunction

	// positive offset inside the 256-word data region, aligned to the size
	function automatic logic [11:0] alignOffset(input logic [11:0] imm, input logic [1:0] size);
		return {2'b00, imm[9:0]} & ~((12'd1 << size) - 12'd1);
	endfunction

	function automatic logic [31:0] randomInst(input int idx);
		logic [31:0] rnd;
		logic [31:0] upper;
		logic [31:0] w;
		logic [11:0] imm;
		logic [2:0] f3;
		logic [4:0] rd;
		int span;
		int hop;
		rnd = $urandom;
		upper = $urandom;
		imm = rnd[11:0];
		f3 = rnd[14:12];
		rd = pickRd();
		span = (ProgLen - 1 - idx < 4) ? ProgLen - 1 - idx : 4;
		hop = 4 * (1 + $urandom % span);
		case ($urandom % 12)
			0, 1: begin
				// shifts carry shamt and the arithmetic bit only
				if (f3 == 3'd1)
					imm = {7'd0, imm[4:0]};
				else if (f3 == 3'd5)
					imm = {1'b0, rnd[30], 5'd0, imm[4:0]};
				w = encI(imm, rnd[19:15], f3, rd, RiscvPkg::OpImm);
			end
			2, 3: w = encR(((f3 == 3'd0 || f3 == 3'd5) && rnd[31]) ? 7'h20 : 7'h00,
					rnd[24:20], rnd[19:15], f3, rd);
			4: w = {upper[31:12], rd, RiscvPkg::OpLui};
			5: w = {upper[31:12], rd, RiscvPkg::OpAuipc};
			6, 7: begin
				if (f3 == 3'd3 || f3 > 3'd5)
					f3 = 3'd2;
				w = encI(alignOffset(imm, f3[1:0]), 5'd2, f3, rd, RiscvPkg::OpLoad);
			end
			8, 9: begin
				f3 = f3 % 3;
				w = encS(alignOffset(imm, f3[1:0]), rnd[24:20], 5'd2, f3);
			end
			10: begin
				if (f3 == 3'd2 || f3 == 3'd3)
					f3 = f3 + 3'd4;
				w = encB(13'(hop), rnd[24:20], rnd[19:15], f3);
			end
			default: w = encJ(21'(hop), rd);
		endcase
		return w;
	endfunction

	function automatic logic [31:0] aluCalc(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic [31:0] r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = {31'd0, $signed(a) < $signed(b)};
			3'd3: r = {31'd0, a < b};
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt)
					r = $signed(a) >>> b[4:0];
				else
					r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branchCond(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// ISA model filling the expected queues
	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] nextPc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [31:0] addr;
		logic [31:0] lw;
		logic [31:0] immI;
		logic wr;
		regWrite_t rw;
		memWrite_t mw;
		int i;
		pc = '0;
		expCount = 0;
		forever begin
			expPcQ.push_back(pc);
			w = imem[pc[AddrWidth-1:2]];
			if (w == RiscvPkg::HaltInst && modelReg[1] == RiscvPkg::HaltMagic)
				break;
			a = modelReg[w[19:15]];
			b = modelReg[w[24:20]];
			immI = {{20{w[31]}}, w[31:20]};
			nextPc = pc + 32'd4;
			wr = 1'b1;
			val = '0;
			case (w[6:0])
				RiscvPkg::OpLui: val = {w[31:12], 12'd0};
				RiscvPkg::OpAuipc: val = pc + {w[31:12], 12'd0};
				RiscvPkg::OpJal: begin
					val = pc + 32'd4;
					nextPc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
				end
				RiscvPkg::OpJalr: begin
					val = pc + 32'd4;
					nextPc = (a + immI) & ~32'd1;
				end
				RiscvPkg::OpBranch: begin
					wr = 1'b0;
					if (branchCond(w[14:12], a, b))
						nextPc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
				end
				RiscvPkg::OpLoad: begin
					addr = a + immI;
					lw = modelMem[addr[AddrWidth-1:2]] >> (8 * addr[1:0]);
					case (w[14:12])
						3'd0: val = {{24{lw[7]}}, lw[7:0]};
						3'd1: val = {{16{lw[15]}}, lw[15:0]};
						3'd4: val = {24'd0, lw[7:0]};
						3'd5: val = {16'd0, lw[15:0]};
						default: val = lw;
					endcase
				end
				RiscvPkg::OpStore: begin
					wr = 1'b0;
					addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
					mw.addr = addr[AddrWidth-1:2];
					if (w[13:12] == 2'd0)
						mw.be = 4'b0001 << addr[1:0];
					else if (w[13:12] == 2'd1)
						mw.be = 4'b0011 << addr[1:0];
					else
						mw.be = 4'b1111;
					mw.data = b << (8 * addr[1:0]);
					for (i = 0; i < 4; i++)
						if (mw.be[i])
							modelMem[addr[AddrWidth-1:2]][8*i +: 8] = mw.data[8*i +: 8];
					expMemQ.push_back(mw);
				end
				RiscvPkg::OpImm: val = aluCalc(w[14:12], w[30] && w[14:12] == 3'd5, a, immI);
				default: val = aluCalc(w[14:12], w[30], a, b);
			endcase
			if (wr && w[11:7] != 5'd0) begin
				modelReg[w[11:7]] = val;
				rw.idx = w[11:7];
				rw.value = val;
				expRegQ.push_back(rw);
			end
			pc = nextPc;
			expCount++;
		end
	endtask

	initial begin
		int i;
		RSTn = 1'b1;
		iMemDi = '0;
		dMemDi = '0;
		void'($urandom(32'hd7af_3ae7));
		for (i = 0; i < 1024; i++) begin
			imem[i] = '0;
			dmem[i] = 32'(i) * 32'h9e37_79b9;
			modelMem[i] = dmem[i];
		end
		for (i = 0; i < 32; i++) begin
			rf[i] = '0;
			modelReg[i] = '0;
		end
		// x2 holds the data base, x1 the halt value
		imem[0] = encI(12'h400, 5'd0, 3'd0, 5'd2, RiscvPkg::OpImm);
		imem[1] = encI(12'd12, 5'd0, 3'd0, 5'd1, RiscvPkg::OpImm);
		for (i = 2; i < ProgLen - 1; i++)
			imem[i] = randomInst(i);
		imem[ProgLen-1] = RiscvPkg::HaltInst;
		runModel();
		repeat (3) @(posedge CLK);
		RSTn <= 1'b0;
	end

	assign rfRd1 = rf[rfRa1];
	assign rfRd2 = rf[rfRa2];

	// memories and register file answering the core
	always @(posedge CLK) begin
		int j;
		if (!iMemCsn)
			iMemDi <= imem[iMemAddr[AddrWidth-1:2]];
		if (!dMemCsn) begin
			dMemDi <= dmem[dMemAddr[AddrWidth-3:0]];
			if (!dMemWen)
				for (j = 0; j < 4; j++)
					if (dMemBe[j])
						dmem[dMemAddr[AddrWidth-3:0]][8*j +: 8] <= dMemDout[8*j +: 8];
		end
		if (rfWe && rfWa1 != 5'd0)
			rf[rfWa1] <= rfWd;
	end

	always @(posedge CLK) begin
		regWrite_t rw;
		memWrite_t mw;
		logic [31:0] mask;
		if (!RSTn) begin
			cycles = cycles + 1;
			if (cycles > CycleLimit)
				failRun($sformatf("core never halted within %0d cycles", CycleLimit));
			assert (RiscvTop_inst.portChk.violations == 0)
			else failRun("a port protocol assertion fired");
			if (!iMemCsn) begin
				assert (expPcQ.size() > 0)
				else failRun("fetch past the last instruction the model executed");
				checkValue("I_MEM_ADDR", 32'(iMemAddr), 32'(expPcQ[0][AddrWidth-1:0]));
				void'(expPcQ.pop_front());
			end
			if (rfWe && rfWa1 != 5'd0) begin
				assert (expRegQ.size() > 0)
				else failRun("register write that the model does not expect");
				rw = expRegQ.pop_front();
				checkValue("RF_WA1", 32'(rfWa1), 32'(rw.idx));
				checkValue("RF_WD", rfWd, rw.value);
				checkValue("OUTPUT_PORT", outputPort, rw.value);
			end
			if (!dMemCsn && !dMemWen) begin
				assert (expMemQ.size() > 0)
				else failRun("store that the model does not expect");
				mw = expMemQ.pop_front();
				mask = {{8{mw.be[3]}}, {8{mw.be[2]}}, {8{mw.be[1]}}, {8{mw.be[0]}}};
				checkValue("D_MEM_ADDR", 32'(dMemAddr), 32'(mw.addr));
				checkValue("D_MEM_BE", 32'(dMemBe), 32'(mw.be));
				checkValue("D_MEM_DOUT", dMemDout & mask, mw.data & mask);
			end
			if (halt) begin
				checkValue("NUM_INST", numInst, expCount);
				if (expRegQ.size() == 0 && expMemQ.size() == 0 && expPcQ.size() == 0) begin
					$display("RESULT: PASS");
					$finish;
				end else begin
					failRun("core halted before all expected writes and fetches were seen");
				end
			end
		end
	end

endmodule

// File: verification/RiscvTop_chk.sv
module RiscvTopChk (
	input logic CLK,
	input logic RSTn,
	input logic iMemCsn,
	input logic dMemCsn,
	input logic dMemWen,
	input logic rfWe,
	input logic halt
);

	// count of failed assertions
	int violations = 0;

	writeNeedsSelect: assert property (@(posedge CLK) disable iff (RSTn) !dMemWen |-> !dMemCsn)
	else begin
		$error("D_MEM_WEN low while D_MEM_CSN is high");
		violations++;
	end

	// one write-back per instruction
	singleWePulse: assert property (@(posedge CLK) disable iff (RSTn) rfWe |=> !rfWe)
	else begin
		$error("RF_WE high for two cycles in a row");
		violations++;
	end

	haltSticky: assert property (@(posedge CLK) disable iff (RSTn) halt |=> halt)
	else begin
		$error("HALT dropped after rising");
		violations++;
	end

	// first cycle out of reset
	selectsIdle: assert property (@(posedge CLK) $fell(RSTn) |-> iMemCsn && dMemCsn)
	else begin
		$error("chip selects not idle after reset");
		violations++;
	end

endmodule
